// ==== list.f ====
source/median_pkg.sv
source/bitplane_if.sv
source/window_buffer.sv
source/bitplane_stage.sv
source/median_output.sv
source/median_filter.sv
tb/tb_median_filter.sv

// ==== tb/tb_median_filter.sv ====
// testbench for the median filter
// clock, reset and LFSR driven stimulus with clock enable gaps and mode changes
// sorting reference model with an expected result queue
// concurrent assertions on o_valid and o_median, bounded waits
`timescale 1ns/10ps

module tb_median_filter import median_pkg::*; ();

	localparam int LATENCY = 10;
	localparam int FIRST_TIMEOUT = 40;
	localparam int MIN_RESULTS = 200;

	logic clk;
	logic rst;
	logic i_clken;
	mode_t i_mode;
	column_t i_column;
	pixel_t o_median;
	logic o_valid;

	logic [15:0] lfsr;

	// reference model state with hist[4] as the newest column
	column_t hist [WIN_DIM];
	int accepted;
	int en_edges;
	int due_q [$];
	pixel_t med_q [$];
	logic exp_valid;
	pixel_t exp_median;
	logic last_en;
	int seen;
	int popped;

	median_filter dut (
		.clk      (clk),
		.rst      (rst),
		.i_clken  (i_clken),
		.i_mode   (i_mode),
		.i_column (i_column),
		.o_median (o_median),
		.o_valid  (o_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	// galois form with taps 16 14 13 11
	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 16'hB400;
		end
		return b;
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(next_bit());
		end
		return v;
	endfunction

	function automatic column_t random_column();
		column_t col;
		for (int r = 0; r < WIN_DIM; r++) begin
			col[r] = pixel_t'(take_bits(PIXEL_W));
		end
		return col;
	endfunction

	// only the two extreme values
	function automatic column_t extreme_column();
		column_t col;
		for (int r = 0; r < WIN_DIM; r++) begin
			col[r] = take_bits(1) ? 8'hFF : 8'h00;
		end
		return col;
	endfunction

	function automatic column_t flat_column(input pixel_t v);
		column_t col;
		for (int r = 0; r < WIN_DIM; r++) begin
			col[r] = v;
		end
		return col;
	endfunction

	// sort the window, or its centre 3x3, and pick the median rank
	function automatic pixel_t window_median(input mode_t m);
		int vals [WIN_N];
		int n;
		int t;
		int j;
		int lo;
		int hi;
		n = 0;
		lo = (m == MODE_3X3) ? 1 : 0;
		hi = (m == MODE_3X3) ? WIN_DIM - 2 : WIN_DIM - 1;
		for (int c = lo; c <= hi; c++) begin
			for (int r = lo; r <= hi; r++) begin
				vals[n] = int'(hist[c][r]);
				n++;
			end
		end
		for (int i = 1; i < n; i++) begin
			t = vals[i];
			j = i - 1;
			while (j >= 0 && vals[j] > t) begin
				vals[j+1] = vals[j];
				j--;
			end
			vals[j+1] = t;
		end
		return pixel_t'(vals[((m == MODE_3X3) ? RANK_3X3 : RANK_5X5) - 1]);
	endfunction

	// inputs read here were driven 1 ns after the previous edge
	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			exp_valid = 1'b0;
			exp_median = '0;
			accepted = 0;
			en_edges = 0;
			last_en = 1'b0;
			seen = 0;
			popped = 0;
			due_q.delete();
			med_q.delete();
		end else begin
			if (last_en && o_valid) begin
				seen++;
			end
			last_en = i_clken;
			if (i_clken) begin
				en_edges++;
				for (int c = 0; c < WIN_DIM - 1; c++) begin
					hist[c] = hist[c+1];
				end
				hist[WIN_DIM-1] = i_column;
				accepted++;
				if (accepted >= WIN_DIM) begin
					due_q.push_back(en_edges + LATENCY);
					med_q.push_back(window_median(i_mode));
				end
				if (due_q.size() > 0 && due_q[0] == en_edges) begin
					exp_valid = 1'b1;
					exp_median = med_q.pop_front();
					void'(due_q.pop_front());
					popped++;
				end else begin
					exp_valid = 1'b0;
				end
			end
		end
	end

	a_valid_match: assert property (
		@(posedge clk) disable iff (!rst)
		o_valid == exp_valid
	) else fail_run($sformatf("Mismatch at time %0t: o_valid %0b, expected %0b",
		$time, $sampled(o_valid), $sampled(exp_valid)));

	a_median_match: assert property (
		@(posedge clk) disable iff (!rst)
		o_median == exp_median
	) else fail_run($sformatf("Mismatch at time %0t: o_median %0d, expected %0d",
		$time, $sampled(o_median), $sampled(exp_median)));

	task automatic drive_cycle(input logic en, input mode_t m, input column_t col);
		@(posedge clk);
		#1;
		i_clken = en;
		i_mode = m;
		i_column = col;
	endtask

	initial begin
		int waited;
		mode_t m;
		logic en;
		lfsr = 16'd54;
		rst = 1'b0;
		i_clken = 1'b0;
		i_mode = MODE_5X5;
		i_column = '0;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
		end
		#1;
		rst = 1'b1;

		// the first result comes 10 enabled edges after the fifth column
		waited = 0;
		while (!o_valid) begin
			if (waited == FIRST_TIMEOUT) begin
				fail_run("no valid output appeared after the window filled");
			end
			drive_cycle(1'b1, MODE_5X5, random_column());
			waited++;
		end
		for (int i = 0; i < 50; i++) begin
			drive_cycle(1'b1, MODE_5X5, random_column());
		end

		for (int i = 0; i < 40; i++) begin
			drive_cycle(1'b1, MODE_3X3, random_column());
		end

		// enable gaps and mode switches mid-stream
		m = MODE_5X5;
		for (int i = 0; i < 150; i++) begin
			en = (take_bits(2) != 0);
			if (take_bits(3) == 0) begin
				m = (m == MODE_5X5) ? MODE_3X3 : MODE_5X5;
			end
			drive_cycle(en, m, random_column());
		end

		// flat windows at mid grey, black and white
		for (int i = 0; i < 8; i++) begin
			drive_cycle(1'b1, MODE_5X5, flat_column(8'hA5));
		end
		for (int i = 0; i < 6; i++) begin
			drive_cycle(1'b1, MODE_3X3, flat_column(8'h00));
		end
		for (int i = 0; i < 6; i++) begin
			drive_cycle(1'b1, MODE_5X5, flat_column(8'hFF));
		end
		for (int i = 0; i < 30; i++) begin
			m = take_bits(1) ? MODE_5X5 : MODE_3X3;
			drive_cycle(1'b1, m, extreme_column());
		end

		for (int i = 0; i < LATENCY + 2; i++) begin
			drive_cycle(1'b1, MODE_5X5, random_column());
		end
		drive_cycle(1'b0, MODE_5X5, '0);
		drive_cycle(1'b0, MODE_5X5, '0);

		if (seen != popped || popped < MIN_RESULTS) begin
			fail_run($sformatf("output count wrong: %0d seen, %0d expected", seen, popped));
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

// ==== source/median_filter.sv ====
// streaming rank-order median filter top level
// window buffer, eight bit-plane stages from MSB down, output stage
// latency of 10 enabled edges from column in to median out
`timescale 1ns/10ps

module median_filter import median_pkg::*; (
	input logic clk,
	input logic rst,
	input logic i_clken,
	input mode_t i_mode,
	input column_t i_column,
	output pixel_t o_median,
	output logic o_valid
);

	// link s feeds the stage for bit PIXEL_W-1-s
	bitplane_if link [0:PIXEL_W] ();

	window_buffer u_window_buffer (
		.clk      (clk),
		.rst      (rst),
		.i_clken  (i_clken),
		.i_column (i_column),
		.i_mode   (i_mode),
		.o_win    (link[0])
	);

	genvar s;
	generate
		for (s = 0; s < PIXEL_W; s++) begin : g_stage
			bitplane_stage #(
				.BIT (PIXEL_W - 1 - s)
			) u_stage (
				.clk     (clk),
				.rst     (rst),
				.i_clken (i_clken),
				.i_prev  (link[s]),
				.o_next  (link[s+1])
			);
		end
	endgenerate

	median_output u_median_output (
		.clk      (clk),
		.rst      (rst),
		.i_clken  (i_clken),
		.i_last   (link[PIXEL_W]),
		.o_median (o_median),
		.o_valid  (o_valid)
	);

endmodule

// ==== source/median_output.sv ====
// final reduction of the surviving pixels to the median
// registered median and valid, frozen while the clock enable is low
`timescale 1ns/10ps

module median_output import median_pkg::*; (
	input logic clk,
	input logic rst,
	input logic i_clken,
	bitplane_if.dst i_last,
	output pixel_t o_median,
	output logic o_valid
);

	pixel_t med_d;
	logic all_same;

	always_comb begin
		med_d = '0;
		for (int i = 0; i < WIN_N; i++) begin
			if (i_last.alive[i]) begin
				med_d = med_d | i_last.pixels[i];
			end
		end
		all_same = 1'b1;
		for (int i = 0; i < WIN_N; i++) begin
			if (i_last.alive[i] && i_last.pixels[i] != med_d) begin
				all_same = 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_median <= '0;
			o_valid <= 1'b0;
		end else if (i_clken) begin
			o_valid <= i_last.valid;
			// only real windows reach the output
			if (i_last.valid) begin
				o_median <= med_d;
			end
		end
	end

	// after eight planes the survivors agree and sit at the rank
	a_survivors_agree: assert property (
		@(posedge clk) disable iff (!rst)
		i_last.valid |-> all_same && (i_last.below < rank_of(i_last.mode))
	) else $error("survivors disagree or rank overrun");

endmodule

// ==== source/bitplane_stage.sv ====
// one bit-plane elimination stage of the median pipeline
// counts surviving zeros in plane BIT and compares against the rank
// drops the survivors on the wrong side, registers the item
`timescale 1ns/10ps

module bitplane_stage import median_pkg::*; #(
	parameter int BIT = PIXEL_W - 1
) (
	input logic clk,
	input logic rst,
	input logic i_clken,
	bitplane_if.dst i_prev,
	bitplane_if.src o_next
);

	count_t zeros;
	count_t total;
	logic median_zero;
	mask_t alive_d;
	count_t below_d;

	logic valid_q;
	mode_t mode_q;
	window_t pixels_q;
	mask_t alive_q;
	count_t below_q;

	always_comb begin
		zeros = '0;
		for (int i = 0; i < WIN_N; i++) begin
			if (i_prev.alive[i] && !i_prev.pixels[i][BIT]) begin
				zeros = zeros + 1'b1;
			end
		end
		total = i_prev.below + zeros;
		// rank reached inside the zero group, so the median has a 0 here
		median_zero = (total >= rank_of(i_prev.mode));
		for (int i = 0; i < WIN_N; i++) begin
			if (median_zero) begin
				alive_d[i] = i_prev.alive[i] & ~i_prev.pixels[i][BIT];
			end else begin
				alive_d[i] = i_prev.alive[i] & i_prev.pixels[i][BIT];
			end
		end
		below_d = median_zero ? i_prev.below : total;
	end

	always_ff @(posedge clk) begin
		if (i_clken) begin
			pixels_q <= i_prev.pixels;
			alive_q <= alive_d;
			below_q <= below_d;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			valid_q <= 1'b0;
			mode_q <= MODE_5X5;
		end else if (i_clken) begin
			valid_q <= i_prev.valid;
			mode_q <= i_prev.mode;
		end
	end

	assign o_next.valid = valid_q;
	assign o_next.mode = mode_q;
	assign o_next.pixels = pixels_q;
	assign o_next.alive = alive_q;
	assign o_next.below = below_q;

	// upstream counts must always leave a survivor
	a_alive_nonempty: assert property (
		@(posedge clk) disable iff (!rst)
		o_next.valid |-> |o_next.alive
	) else $error("bit %0d stage emptied the alive mask", BIT);

endmodule

// ==== source/window_buffer.sv ====
// column shift register building the 5x5 window
// saturating fill counter that raises valid once five columns are in
// registered row-major window with its mode for the first stage
`timescale 1ns/10ps

module window_buffer import median_pkg::*; (
	input logic clk,
	input logic rst,
	input logic i_clken,
	input column_t i_column,
	input mode_t i_mode,
	bitplane_if.src o_win
);

	// cols[0] is the newest column
	column_t [WIN_DIM-1:0] cols;
	mode_t mode_q;
	count_t fill;

	window_t win_d;
	window_t win_pixels;
	mode_t win_mode;
	logic win_valid;

	// reorder columns into row-major, oldest column on the left
	always_comb begin
		for (int r = 0; r < WIN_DIM; r++) begin
			for (int c = 0; c < WIN_DIM; c++) begin
				win_d[r * WIN_DIM + c] = cols[WIN_DIM-1-c][r];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_clken) begin
			cols <= {cols[WIN_DIM-2:0], i_column};
			win_pixels <= win_d;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fill <= '0;
			mode_q <= MODE_5X5;
			win_mode <= MODE_5X5;
			win_valid <= 1'b0;
		end else if (i_clken) begin
			if (fill != count_t'(WIN_DIM)) begin
				fill <= fill + 1'b1;
			end
			// mode travels with the newest column
			mode_q <= i_mode;
			win_mode <= mode_q;
			win_valid <= (fill == count_t'(WIN_DIM));
		end
	end

	assign o_win.valid = win_valid;
	assign o_win.mode = win_mode;
	assign o_win.pixels = win_pixels;
	assign o_win.alive = centre_mask(win_mode);
	assign o_win.below = '0;

	// fill counter saturates at the window width
	a_fill_bound: assert property (
		@(posedge clk) disable iff (!rst)
		fill <= count_t'(WIN_DIM)
	) else $error("window fill counter above %0d", WIN_DIM);

endmodule

// ==== source/bitplane_if.sv ====
// link between two median pipeline stages
// one window item: valid, mode, pixels, alive flags, eliminated-below count
// src drives the item, dst reads it
`timescale 1ns/10ps

interface bitplane_if import median_pkg::*; ();

	logic valid;
	mode_t mode;
	window_t pixels;
	mask_t alive;
	// pixels already known to be smaller than the median
	count_t below;

	modport src (
		output valid,
		output mode,
		output pixels,
		output alive,
		output below
	);

	modport dst (
		input valid,
		input mode,
		input pixels,
		input alive,
		input below
	);

endinterface

// ==== source/median_pkg.sv ====
// shared sizes, ranks and types for the median filter
// pixel, column, window, mask and count types
// window mode encoding with rank and initial alive mask lookups
package median_pkg;

	localparam int PIXEL_W = 8;
	localparam int WIN_DIM = 5;
	localparam int WIN_N = WIN_DIM * WIN_DIM;
	localparam int CNT_W = 5;

	// 1-based median ranks
	localparam int RANK_5X5 = 13;
	localparam int RANK_3X3 = 5;

	typedef logic [PIXEL_W-1:0] pixel_t;
	// index is the row, 0 at the top
	typedef pixel_t [WIN_DIM-1:0] column_t;
	// row-major, index row * WIN_DIM + col, col 0 is the oldest column
	typedef pixel_t [WIN_N-1:0] window_t;
	typedef logic [WIN_N-1:0] mask_t;
	typedef logic [CNT_W-1:0] count_t;

	typedef enum logic [0:0] {
		MODE_3X3 = 1'b0,
		MODE_5X5 = 1'b1
	} mode_t;

	function automatic count_t rank_of(mode_t m);
		return (m == MODE_3X3) ? count_t'(RANK_3X3) : count_t'(RANK_5X5);
	endfunction

	// 3x3 mode keeps only the centre of the window
	function automatic mask_t centre_mask(mode_t m);
		mask_t mask;
		mask = '1;
		if (m == MODE_3X3) begin
			mask = '0;
			for (int r = 1; r < WIN_DIM - 1; r++) begin
				for (int c = 1; c < WIN_DIM - 1; c++) begin
					mask[r * WIN_DIM + c] = 1'b1;
				end
			end
		end
		return mask;
	endfunction

endpackage
